/* src/pid_config.svh */
`ifndef PID_CONFIG_SVH
`define PID_CONFIG_SVH

// Channel space
`define PID_N_CHAN      8
`define PID_W_CHAN      3

// Datapath widths
`define PID_W_DATA      16
`define PID_W_COEF      16
`define PID_FRAC        8
`define PID_W_ACC       32

// Output mapping, DAC channels first and DDS right after
`define PID_N_DAC       4
`define PID_N_DDS       2
`define PID_W_DAC_CHAN  2
`define PID_W_DDS_SEL   1

// Command queue depth
`define PID_Q_DEPTH     8

// Register write port
`define PID_W_ADDR        3
`define PID_ADDR_SETPOINT 3'd0
`define PID_ADDR_KP       3'd1
`define PID_ADDR_KI       3'd2
`define PID_ADDR_KD       3'd3
`define PID_ADDR_LIMIT_HI 3'd4
`define PID_ADDR_LIMIT_LO 3'd5
`define PID_ADDR_CLEAR    3'd6

`endif

/* src/pid_pkg.sv */
`include "pid_config.svh"

package pid_pkg;

    // One ADC sample with its channel tag
    typedef struct packed {
        logic                          stb;
        logic [`PID_W_CHAN-1:0]        chan;
        logic signed [`PID_W_DATA-1:0] data;
    } sample_t;

    // Register write port
    typedef struct packed {
        logic                   stb;
        logic [`PID_W_ADDR-1:0] addr;
        logic [`PID_W_CHAN-1:0] chan;
        logic [`PID_W_DATA-1:0] data;
    } cfg_wr_t;

    // Coefficients and limits of one channel
    typedef struct packed {
        logic signed [`PID_W_DATA-1:0] setpoint;
        logic signed [`PID_W_COEF-1:0] kp;
        logic signed [`PID_W_COEF-1:0] ki;
        logic signed [`PID_W_COEF-1:0] kd;
        logic signed [`PID_W_DATA-1:0] limit_hi;
        logic signed [`PID_W_DATA-1:0] limit_lo;
    } pid_param_t;

    typedef struct packed {
        logic                          stb;
        logic [`PID_W_CHAN-1:0]        chan;
        logic signed [`PID_W_DATA-1:0] data;
    } pid_result_t;

    // --------------------
    // Queue payloads

    typedef struct packed {
        logic [`PID_W_DAC_CHAN-1:0] chan;
        logic [`PID_W_DATA-1:0]     code;
    } dac_cmd_t;

    typedef struct packed {
        logic [`PID_W_DDS_SEL-1:0] sel;
        logic [`PID_W_DATA-1:0]    word;
    } dds_cmd_t;

endpackage

/* src/sync_fifo.sv */
module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 8
) (
    input  logic wr_en,
    input  logic reset,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic valid,
    output logic full
);
    localparam int W_PTR = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int W_CNT = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [W_PTR-1:0] wr_ptr;
    logic [W_PTR-1:0] rd_ptr;
    logic [W_CNT-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pop without an entry is ignored, a full queue still takes a push when it pops
    assign do_pop  = pop && valid;
    assign do_push = push && (!full || do_pop);

    assign valid = (count != '0);
    assign full  = (count == W_CNT'(DEPTH));
    assign dout  = mem[rd_ptr];

    always_ff @(posedge wr_en) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge wr_en) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == W_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == W_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* src/pid_param_bank.sv */
`include "pid_config.svh"

module pid_param_bank
    import pid_pkg::*;
(
    input  logic                   wr_en,
    input  logic                   reset,
    input  cfg_wr_t                cfg,
    input  logic [`PID_W_CHAN-1:0] rd_chan,
    output pid_param_t             param,
    output logic                   clear,
    output logic [`PID_W_CHAN-1:0] clear_chan
);
    localparam int N = `PID_N_CHAN;
    localparam int W = `PID_W_DATA;

    logic signed [W-1:0]             setpoint_mem [N];
    logic signed [`PID_W_COEF-1:0]   kp_mem [N];
    logic signed [`PID_W_COEF-1:0]   ki_mem [N];
    logic signed [`PID_W_COEF-1:0]   kd_mem [N];
    logic signed [W-1:0]             limit_hi_mem [N];
    logic signed [W-1:0]             limit_lo_mem [N];

    // --------------------
    // Register writes
    always_ff @(posedge wr_en) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                setpoint_mem[i] <= '0;
                kp_mem[i]       <= '0;
                ki_mem[i]       <= '0;
                kd_mem[i]       <= '0;
                // Full signed range until the host narrows it
                limit_hi_mem[i] <= {1'b0, {(W - 1){1'b1}}};
                limit_lo_mem[i] <= {1'b1, {(W - 1){1'b0}}};
            end
        end else if (cfg.stb) begin
            case (cfg.addr)
                `PID_ADDR_SETPOINT: setpoint_mem[cfg.chan] <= cfg.data;
                `PID_ADDR_KP:       kp_mem[cfg.chan]       <= cfg.data;
                `PID_ADDR_KI:       ki_mem[cfg.chan]       <= cfg.data;
                `PID_ADDR_KD:       kd_mem[cfg.chan]       <= cfg.data;
                `PID_ADDR_LIMIT_HI: limit_hi_mem[cfg.chan] <= cfg.data;
                `PID_ADDR_LIMIT_LO: limit_lo_mem[cfg.chan] <= cfg.data;
                default: ;
            endcase
        end
    end

    // Clear is a command, nothing is stored for it
    always_ff @(posedge wr_en) begin
        if (reset) begin
            clear <= 1'b0;
        end else begin
            clear <= cfg.stb && (cfg.addr == `PID_ADDR_CLEAR);
        end
    end

    always_ff @(posedge wr_en) begin
        clear_chan <= cfg.chan;
    end

    // Lookup for the pipeline
    assign param.setpoint = setpoint_mem[rd_chan];
    assign param.kp       = kp_mem[rd_chan];
    assign param.ki       = ki_mem[rd_chan];
    assign param.kd       = kd_mem[rd_chan];
    assign param.limit_hi = limit_hi_mem[rd_chan];
    assign param.limit_lo = limit_lo_mem[rd_chan];

endmodule

/* src/pid_pipeline.sv */
`include "pid_config.svh"

module pid_pipeline
    import pid_pkg::*;
(
    input  logic                   wr_en,
    input  logic                   reset,
    input  sample_t                sample,
    output logic [`PID_W_CHAN-1:0] rd_chan,
    input  pid_param_t             param,
    input  logic                   clear,
    input  logic [`PID_W_CHAN-1:0] clear_chan,
    output pid_result_t            result
);
    localparam int W_ERR  = `PID_W_DATA + 1;
    localparam int W_DIFF = W_ERR + 1;
    localparam int W_SUM  = `PID_W_COEF + `PID_W_ACC + 2;

    logic                          s1_stb;
    logic [`PID_W_CHAN-1:0]        s1_chan;
    pid_param_t                    s1_param;
    logic signed [W_ERR-1:0]       s1_err;
    logic signed [W_ERR-1:0]       err_now;

    logic signed [`PID_W_ACC-1:0]  acc_mem [`PID_N_CHAN];
    logic signed [W_ERR-1:0]       eprev_mem [`PID_N_CHAN];
    logic signed [`PID_W_ACC-1:0]  acc_new;
    logic signed [W_DIFF-1:0]      diff_now;

    logic                          s2_stb;
    logic [`PID_W_CHAN-1:0]        s2_chan;
    logic signed [W_ERR-1:0]       s2_err;
    logic signed [`PID_W_ACC-1:0]  s2_acc;
    logic signed [W_DIFF-1:0]      s2_diff;
    pid_param_t                    s2_param;

    logic                          s3_stb;
    logic [`PID_W_CHAN-1:0]        s3_chan;
    logic signed [W_SUM-1:0]       s3_p;
    logic signed [W_SUM-1:0]       s3_i;
    logic signed [W_SUM-1:0]       s3_d;
    logic signed [`PID_W_DATA-1:0] s3_hi;
    logic signed [`PID_W_DATA-1:0] s3_lo;

    logic signed [W_SUM-1:0]       sum;
    logic signed [W_SUM-1:0]       shifted;
    logic signed [`PID_W_DATA-1:0] clamped;
    logic                          res_stb;
    logic [`PID_W_CHAN-1:0]        res_chan;
    logic signed [`PID_W_DATA-1:0] res_data;

    // Strobes of all four stages
    always_ff @(posedge wr_en) begin
        if (reset) begin
            s1_stb  <= 1'b0;
            s2_stb  <= 1'b0;
            s3_stb  <= 1'b0;
            res_stb <= 1'b0;
        end else begin
            s1_stb  <= sample.stb;
            s2_stb  <= s1_stb;
            s3_stb  <= s2_stb;
            res_stb <= s3_stb;
        end
    end

    // --------------------
    // Stage 1 lookup and error
    assign rd_chan = sample.chan;
    assign err_now = W_ERR'($signed(param.setpoint)) - W_ERR'($signed(sample.data));

    always_ff @(posedge wr_en) begin
        s1_chan  <= sample.chan;
        s1_param <= param;
        s1_err   <= err_now;
    end

    // --------------------
    // Stage 2 per-channel state, written back so the next sample sees it
    assign acc_new  = acc_mem[s1_chan] + `PID_W_ACC'(s1_err);
    assign diff_now = W_DIFF'(s1_err) - W_DIFF'(eprev_mem[s1_chan]);

    always_ff @(posedge wr_en) begin
        if (reset) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                acc_mem[i]   <= '0;
                eprev_mem[i] <= '0;
            end
        end else begin
            if (s1_stb) begin
                acc_mem[s1_chan]   <= acc_new;
                eprev_mem[s1_chan] <= s1_err;
            end
            // A clear wins over an update in the same cycle
            if (clear) begin
                acc_mem[clear_chan]   <= '0;
                eprev_mem[clear_chan] <= '0;
            end
        end
    end

    always_ff @(posedge wr_en) begin
        s2_chan  <= s1_chan;
        s2_err   <= s1_err;
        s2_acc   <= acc_new;
        s2_diff  <= diff_now;
        s2_param <= s1_param;
    end

    // --------------------
    // Stage 3 products
    always_ff @(posedge wr_en) begin
        s3_chan <= s2_chan;
        s3_p    <= $signed(s2_param.kp) * s2_err;
        s3_i    <= $signed(s2_param.ki) * s2_acc;
        s3_d    <= $signed(s2_param.kd) * s2_diff;
        s3_hi   <= s2_param.limit_hi;
        s3_lo   <= s2_param.limit_lo;
    end

    // --------------------
    // Stage 4 sum, scale, clamp
    assign sum     = s3_p + s3_i + s3_d;
    assign shifted = sum >>> `PID_FRAC;

    always_comb begin
        if (shifted > W_SUM'(s3_hi)) begin
            clamped = s3_hi;
        end else if (shifted < W_SUM'(s3_lo)) begin
            clamped = s3_lo;
        end else begin
            clamped = shifted[`PID_W_DATA-1:0];
        end
    end

    always_ff @(posedge wr_en) begin
        res_chan <= s3_chan;
        res_data <= clamped;
    end

    assign result.stb  = res_stb;
    assign result.chan = res_chan;
    assign result.data = res_data;

endmodule

/* src/output_router.sv */
`include "pid_config.svh"

module output_router
    import pid_pkg::*;
(
    input  logic        wr_en,
    input  logic        reset,
    input  pid_result_t result,
    output logic        dac_push,
    output dac_cmd_t    dac_data,
    input  logic        dac_full,
    output logic        dds_push,
    output dds_cmd_t    dds_data,
    input  logic        dds_full,
    output logic        dac_overflow,
    output logic        dds_overflow
);
    logic                   to_dac;
    logic                   to_dds;
    logic [`PID_W_CHAN-1:0] dds_idx;

    // Channel map: DAC block first, DDS block after it, the rest unused
    assign to_dac  = result.stb && (result.chan < `PID_W_CHAN'(`PID_N_DAC));
    assign to_dds  = result.stb && (result.chan >= `PID_W_CHAN'(`PID_N_DAC))
                     && (result.chan < `PID_W_CHAN'(`PID_N_DAC + `PID_N_DDS));
    assign dds_idx = result.chan - `PID_W_CHAN'(`PID_N_DAC);

    assign dac_data.chan = result.chan[`PID_W_DAC_CHAN-1:0];
    assign dac_data.code = result.data;
    assign dds_data.sel  = dds_idx[`PID_W_DDS_SEL-1:0];
    // Same bits, read as an unsigned tuning word
    assign dds_data.word = result.data;

    assign dac_push = to_dac && !dac_full;
    assign dds_push = to_dds && !dds_full;

    // Sticky drop flags
    always_ff @(posedge wr_en) begin
        if (reset) begin
            dac_overflow <= 1'b0;
            dds_overflow <= 1'b0;
        end else begin
            if (to_dac && dac_full) begin
                dac_overflow <= 1'b1;
            end
            if (to_dds && dds_full) begin
                dds_overflow <= 1'b1;
            end
        end
    end

endmodule

/* src/pid_subsystem.sv */
`include "pid_config.svh"

module pid_subsystem
    import pid_pkg::*;
(
    input  logic     wr_en,
    input  logic     reset,
    input  sample_t  sample,
    input  cfg_wr_t  cfg,
    input  logic     dac_ready,
    output logic     dac_valid,
    output dac_cmd_t dac_cmd,
    input  logic     dds_ready,
    output logic     dds_valid,
    output dds_cmd_t dds_cmd,
    output logic     dac_overflow,
    output logic     dds_overflow
);
    logic [`PID_W_CHAN-1:0] rd_chan;
    pid_param_t             param;
    logic                   clear;
    logic [`PID_W_CHAN-1:0] clear_chan;
    pid_result_t            result;
    logic                   dac_push;
    dac_cmd_t               dac_data;
    logic                   dac_full;
    logic                   dds_push;
    dds_cmd_t               dds_data;
    logic                   dds_full;

    pid_param_bank u_param_bank (
        .wr_en      (wr_en),
        .reset      (reset),
        .cfg        (cfg),
        .rd_chan    (rd_chan),
        .param      (param),
        .clear      (clear),
        .clear_chan (clear_chan)
    );

    pid_pipeline u_pipeline (
        .wr_en      (wr_en),
        .reset      (reset),
        .sample     (sample),
        .rd_chan    (rd_chan),
        .param      (param),
        .clear      (clear),
        .clear_chan (clear_chan),
        .result     (result)
    );

    output_router u_router (
        .wr_en        (wr_en),
        .reset        (reset),
        .result       (result),
        .dac_push     (dac_push),
        .dac_data     (dac_data),
        .dac_full     (dac_full),
        .dds_push     (dds_push),
        .dds_data     (dds_data),
        .dds_full     (dds_full),
        .dac_overflow (dac_overflow),
        .dds_overflow (dds_overflow)
    );

    // --------------------
    // Command queues toward the converter controllers
    sync_fifo #(
        .T     (dac_cmd_t),
        .DEPTH (`PID_Q_DEPTH)
    ) u_dac_queue (
        .wr_en (wr_en),
        .reset (reset),
        .push  (dac_push),
        .din   (dac_data),
        .pop   (dac_ready),
        .dout  (dac_cmd),
        .valid (dac_valid),
        .full  (dac_full)
    );

    sync_fifo #(
        .T     (dds_cmd_t),
        .DEPTH (`PID_Q_DEPTH)
    ) u_dds_queue (
        .wr_en (wr_en),
        .reset (reset),
        .push  (dds_push),
        .din   (dds_data),
        .pop   (dds_ready),
        .dout  (dds_cmd),
        .valid (dds_valid),
        .full  (dds_full)
    );

endmodule

/* sim/pid_assert.sv */
`include "pid_config.svh"

module pid_assert
    import pid_pkg::*;
(
    input logic     wr_en,
    input logic     reset,
    input logic     dac_valid,
    input logic     dds_valid,
    input dds_cmd_t dds_cmd,
    input logic     dac_overflow,
    input logic     dds_overflow
);
    timeunit 1ns;
    timeprecision 100ps;

    // Both queues come out of reset empty
    valid_after_reset: assert property (
        @(posedge wr_en) reset |=> (!dac_valid && !dds_valid)
    ) else $error("queue valid high in the cycle after reset");

    // --------------------
    // Sticky drop flags
    dac_overflow_sticky: assert property (
        @(posedge wr_en) disable iff (reset) dac_overflow |=> dac_overflow
    ) else $error("dac_overflow fell outside reset");

    dds_overflow_sticky: assert property (
        @(posedge wr_en) disable iff (reset) dds_overflow |=> dds_overflow
    ) else $error("dds_overflow fell outside reset");

    dds_sel_range: assert property (
        @(posedge wr_en) disable iff (reset)
            dds_valid |-> (int'(dds_cmd.sel) < `PID_N_DDS)
    ) else $error("dds_cmd select out of range while valid");

endmodule

/* sim/pid_checker.sv */
`include "pid_config.svh"

module pid_checker
    import pid_pkg::*;
(
    input  logic     wr_en,
    input  logic     reset,
    input  sample_t  sample,
    input  cfg_wr_t  cfg,
    input  logic     dac_valid,
    input  logic     dac_ready,
    input  dac_cmd_t dac_cmd,
    input  logic     dds_valid,
    input  logic     dds_ready,
    input  dds_cmd_t dds_cmd,
    input  logic     dac_overflow,
    input  logic     dds_overflow,
    input  int       test_id,
    output int       errors,
    output int       pending
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N     = `PID_N_CHAN;
    localparam int DELAY = 4;

    pid_param_t                   par [N];
    logic signed [`PID_W_ACC-1:0] acc [N];
    int                           eprev [N];
    logic                         pipe_stb [DELAY];
    logic [`PID_W_CHAN-1:0]       pipe_chan [DELAY];
    logic [`PID_W_DATA-1:0]       pipe_data [DELAY];
    dac_cmd_t                     exp_dac [$];
    dds_cmd_t                     exp_dds [$];
    logic                         exp_dac_ovf;
    logic                         exp_dds_ovf;

    function automatic string test_label(input int id);
        case (id)
            1:       return "proportional";
            2:       return "integral_clear";
            3:       return "derivative";
            4:       return "clamping";
            5:       return "routing_backpressure";
            default: return "setup";
        endcase
    endfunction

    // --------------------
    // Reference PID step
    function automatic logic signed [15:0] pid_ref(
        input pid_param_t                   p,
        input logic signed [`PID_W_DATA-1:0] x,
        input logic signed [`PID_W_ACC-1:0]  acc_old,
        input int                            e_prev
    );
        int                           e;
        logic signed [`PID_W_ACC-1:0] acc_new;
        longint                       raw;
        e       = int'(p.setpoint) - int'(x);
        acc_new = acc_old + e;
        raw     = longint'(p.kp) * e + longint'(p.ki) * acc_new
                  + longint'(p.kd) * (e - e_prev);
        raw     = raw >>> `PID_FRAC;
        if (raw > longint'(p.limit_hi)) begin
            return p.limit_hi;
        end else if (raw < longint'(p.limit_lo)) begin
            return p.limit_lo;
        end
        return 16'(raw);
    endfunction

    // Expected command for a result reaching the router
    task automatic route_result(
        input logic [`PID_W_CHAN-1:0] chan,
        input logic [`PID_W_DATA-1:0] data,
        input bit                     dac_full,
        input bit                     dds_full
    );
        dac_cmd_t dc;
        dds_cmd_t sc;
        if (int'(chan) < `PID_N_DAC) begin
            dc.chan = chan[`PID_W_DAC_CHAN-1:0];
            dc.code = data;
            if (dac_full) begin
                exp_dac_ovf = 1'b1;
            end else begin
                exp_dac.push_back(dc);
            end
        end else if (int'(chan) < `PID_N_DAC + `PID_N_DDS) begin
            sc.sel  = `PID_W_DDS_SEL'(int'(chan) - `PID_N_DAC);
            sc.word = data;
            if (dds_full) begin
                exp_dds_ovf = 1'b1;
            end else begin
                exp_dds.push_back(sc);
            end
        end
    endtask

    always @(posedge wr_en) begin
        bit                     dac_full;
        bit                     dds_full;
        int                     c;
        int                     e;
        int                     busy;
        logic                   out_stb;
        logic [`PID_W_CHAN-1:0] out_chan;
        logic [`PID_W_DATA-1:0] out_data;
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                par[i]          = '0;
                par[i].limit_hi = 16'sh7fff;
                par[i].limit_lo = 16'sh8000;
                acc[i]          = '0;
                eprev[i]        = 0;
            end
            for (int i = 0; i < DELAY; i++) begin
                pipe_stb[i] = 1'b0;
            end
            exp_dac.delete();
            exp_dds.delete();
            exp_dac_ovf = 1'b0;
            exp_dds_ovf = 1'b0;
            errors      = 0;
            pending     = 0;
        end else begin
            // Flags lag the dropped push by one edge
            if (dac_overflow !== exp_dac_ovf) begin
                errors++;
                $display("FAILED %s: dac_overflow expected %0b, actual %0b",
                         test_label(test_id), exp_dac_ovf, dac_overflow);
            end
            if (dds_overflow !== exp_dds_ovf) begin
                errors++;
                $display("FAILED %s: dds_overflow expected %0b, actual %0b",
                         test_label(test_id), exp_dds_ovf, dds_overflow);
            end

            // Occupancy before this edge decides a drop
            dac_full = (exp_dac.size() == `PID_Q_DEPTH);
            dds_full = (exp_dds.size() == `PID_Q_DEPTH);

            // --------------------
            // Popped commands
            if (dac_valid && dac_ready) begin
                if (exp_dac.size() == 0) begin
                    errors++;
                    $display("ERROR in %s: DAC command arrived while none was expected",
                             test_label(test_id));
                end else begin
                    if (dac_cmd !== exp_dac[0]) begin
                        errors++;
                        $display("FAILED %s: expected DAC chan %0d code %h, actual chan %0d code %h",
                                 test_label(test_id), exp_dac[0].chan, exp_dac[0].code,
                                 dac_cmd.chan, dac_cmd.code);
                    end
                    void'(exp_dac.pop_front());
                end
            end
            if (dds_valid && dds_ready) begin
                if (exp_dds.size() == 0) begin
                    errors++;
                    $display("ERROR in %s: DDS command arrived while none was expected",
                             test_label(test_id));
                end else begin
                    if (dds_cmd !== exp_dds[0]) begin
                        errors++;
                        $display("FAILED %s: expected DDS sel %0d word %h, actual sel %0d word %h",
                                 test_label(test_id), exp_dds[0].sel, exp_dds[0].word,
                                 dds_cmd.sel, dds_cmd.word);
                    end
                    void'(exp_dds.pop_front());
                end
            end

            // Four-cycle latency from sample to router
            out_stb  = pipe_stb[DELAY-1];
            out_chan = pipe_chan[DELAY-1];
            out_data = pipe_data[DELAY-1];
            for (int i = DELAY - 1; i > 0; i--) begin
                pipe_stb[i]  = pipe_stb[i-1];
                pipe_chan[i] = pipe_chan[i-1];
                pipe_data[i] = pipe_data[i-1];
            end
            pipe_stb[0] = 1'b0;
            if (out_stb) begin
                route_result(out_chan, out_data, dac_full, dds_full);
            end

            // --------------------
            // Register port and samples
            if (cfg.stb) begin
                c = int'(cfg.chan);
                case (cfg.addr)
                    `PID_ADDR_SETPOINT: par[c].setpoint = cfg.data;
                    `PID_ADDR_KP:       par[c].kp       = cfg.data;
                    `PID_ADDR_KI:       par[c].ki       = cfg.data;
                    `PID_ADDR_KD:       par[c].kd       = cfg.data;
                    `PID_ADDR_LIMIT_HI: par[c].limit_hi = cfg.data;
                    `PID_ADDR_LIMIT_LO: par[c].limit_lo = cfg.data;
                    `PID_ADDR_CLEAR: begin
                        acc[c]   = '0;
                        eprev[c] = 0;
                    end
                    default: ;
                endcase
            end
            if (sample.stb) begin
                c            = int'(sample.chan);
                pipe_stb[0]  = 1'b1;
                pipe_chan[0] = sample.chan;
                pipe_data[0] = pid_ref(par[c], sample.data, acc[c], eprev[c]);
                e            = int'(par[c].setpoint) - int'(sample.data);
                acc[c]       = acc[c] + e;
                eprev[c]     = e;
            end

            busy = 0;
            for (int i = 0; i < DELAY; i++) begin
                if (pipe_stb[i]) begin
                    busy++;
                end
            end
            pending = busy + exp_dac.size() + exp_dds.size();
        end
    end

endmodule

/* sim/pid_tb.sv */
`include "pid_config.svh"

module pid_tb
    import pid_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Whole test sequence stays well below this, four times margin
    localparam int RUN_CYCLES = 5000;
    localparam int MAX_CYCLES = 4 * RUN_CYCLES;

    logic     wr_en;
    logic     reset;
    sample_t  sample;
    cfg_wr_t  cfg;
    logic     dac_ready;
    logic     dac_valid;
    dac_cmd_t dac_cmd;
    logic     dds_ready;
    logic     dds_valid;
    dds_cmd_t dds_cmd;
    logic     dac_overflow;
    logic     dds_overflow;
    int       test_id;
    int       chk_errors;
    int       pending;
    int       tb_errors;
    int       cycles;

    pid_subsystem u_pid_subsystem (
        .wr_en        (wr_en),
        .reset        (reset),
        .sample       (sample),
        .cfg          (cfg),
        .dac_ready    (dac_ready),
        .dac_valid    (dac_valid),
        .dac_cmd      (dac_cmd),
        .dds_ready    (dds_ready),
        .dds_valid    (dds_valid),
        .dds_cmd      (dds_cmd),
        .dac_overflow (dac_overflow),
        .dds_overflow (dds_overflow)
    );

    pid_checker u_checker (
        .wr_en        (wr_en),
        .reset        (reset),
        .sample       (sample),
        .cfg          (cfg),
        .dac_valid    (dac_valid),
        .dac_ready    (dac_ready),
        .dac_cmd      (dac_cmd),
        .dds_valid    (dds_valid),
        .dds_ready    (dds_ready),
        .dds_cmd      (dds_cmd),
        .dac_overflow (dac_overflow),
        .dds_overflow (dds_overflow),
        .test_id      (test_id),
        .errors       (chk_errors),
        .pending      (pending)
    );

    bind pid_subsystem pid_assert u_pid_assert (
        .wr_en        (wr_en),
        .reset        (reset),
        .dac_valid    (dac_valid),
        .dds_valid    (dds_valid),
        .dds_cmd      (dds_cmd),
        .dac_overflow (dac_overflow),
        .dds_overflow (dds_overflow)
    );

    initial wr_en = 1'b0;
    always #5 wr_en = ~wr_en;

    // --------------------
    // Drive helpers, 1 ns after the rising edge
    task automatic tick();
        @(posedge wr_en);
        #1;
        sample.stb = 1'b0;
        cfg.stb    = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [2:0] chan,
                             input logic [15:0] data);
        tick();
        cfg.stb  = 1'b1;
        cfg.addr = addr;
        cfg.chan = chan;
        cfg.data = data;
    endtask

    task automatic send_sample(input logic [2:0] chan, input logic [15:0] data);
        tick();
        sample.stb  = 1'b1;
        sample.chan = chan;
        sample.data = data;
    endtask

    // Until the checker expects nothing more
    task automatic wait_drained();
        do begin
            tick();
        end while (pending != 0);
    endtask

    task automatic finish_run();
        int total;
        total = chk_errors + tb_errors;
        $display("Errors: %0d checker, %0d testbench, %0d total",
                 chk_errors, tb_errors, total);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // --------------------
    // Tests
    task automatic test_proportional();
        test_id = 1;
        for (int c = 0; c < `PID_N_DAC; c++) begin
            write_reg(`PID_ADDR_SETPOINT, 3'(c), 16'($urandom_range(0, 4095)));
            write_reg(`PID_ADDR_KP, 3'(c), 16'($urandom_range(16, 512)));
        end
        repeat (40) send_sample(3'($urandom_range(0, 3)), 16'($urandom));
        wait_drained();
    endtask

    task automatic test_integral_clear();
        test_id = 2;
        write_reg(`PID_ADDR_KP, 3'd2, 16'd0);
        write_reg(`PID_ADDR_KI, 3'd2, 16'd64);
        write_reg(`PID_ADDR_SETPOINT, 3'd2, 16'd100);
        write_reg(`PID_ADDR_CLEAR, 3'd2, 16'd0);
        repeat (10) send_sample(3'd2, 16'd40);
        wait_drained();
        write_reg(`PID_ADDR_CLEAR, 3'd2, 16'd0);
        repeat (5) send_sample(3'd2, 16'd40);
        wait_drained();
    endtask

    task automatic test_derivative();
        test_id = 3;
        write_reg(`PID_ADDR_KP, 3'd3, 16'd0);
        write_reg(`PID_ADDR_KD, 3'd3, 16'd256);
        write_reg(`PID_ADDR_SETPOINT, 3'd3, 16'd0);
        write_reg(`PID_ADDR_CLEAR, 3'd3, 16'd0);
        // Back to back on one channel
        repeat (16) send_sample(3'd3, 16'(int'($urandom_range(0, 8191)) - 4096));
        wait_drained();
    endtask

    task automatic test_clamping();
        test_id = 4;
        write_reg(`PID_ADDR_LIMIT_HI, 3'd0, 16'd1000);
        write_reg(`PID_ADDR_LIMIT_LO, 3'd0, 16'hfc18);
        write_reg(`PID_ADDR_KP, 3'd0, 16'd4096);
        repeat (20) send_sample(3'd0, 16'(int'($urandom_range(0, 12000)) - 6000));
        wait_drained();
    endtask

    task automatic test_routing_backpressure();
        test_id = 5;
        for (int c = `PID_N_DAC; c < `PID_N_CHAN; c++) begin
            write_reg(`PID_ADDR_KP, 3'(c), 16'd256);
        end
        repeat (40) send_sample(3'($urandom_range(0, 7)), 16'($urandom));
        wait_drained();
        dds_ready = 1'b0;
        repeat (12) send_sample(3'($urandom_range(4, 5)), 16'($urandom));
        do begin
            tick();
        end while (pending != `PID_Q_DEPTH);
        if (dds_overflow !== 1'b1) begin
            tb_errors++;
            $display("FAILED routing_backpressure: dds_overflow expected 1, actual %0b",
                     dds_overflow);
        end
        dds_ready = 1'b1;
        wait_drained();
    endtask

    initial begin
        void'($urandom(32'h5b470d59));
        tb_errors = 0;
        test_id   = 0;
        reset     = 1'b1;
        sample    = '0;
        cfg       = '0;
        dac_ready = 1'b0;
        dds_ready = 1'b0;
        repeat (4) @(posedge wr_en);
        #1;
        reset     = 1'b0;
        dac_ready = 1'b1;
        dds_ready = 1'b1;
        test_proportional();
        test_integral_clear();
        test_derivative();
        test_clamping();
        test_routing_backpressure();
        tick();
        finish_run();
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge wr_en);
            cycles++;
        end
        tb_errors++;
        $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
        finish_run();
    end

endmodule

/* flist.f */
+incdir+src
src/pid_pkg.sv
src/sync_fifo.sv
src/pid_param_bank.sv
src/pid_pipeline.sv
src/output_router.sv
src/pid_subsystem.sv
sim/pid_assert.sv
sim/pid_checker.sv
sim/pid_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pid_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Everything OK

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) src/pid_config.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
